// ==== gfx_raster.f ====
+incdir+include
source/gfx_pkg.sv
source/gfx_pipeline_flow.sv
source/gfx_setup.sv
source/gfx_raster_coarse.sv
source/gfx_raster_fine.sv
source/gfx_raster.sv
verif/gfx_raster_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = gfx_raster_tb
FILELIST  = gfx_raster.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

SOURCES = $(wildcard include/*.svh source/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/gfx_raster_tb.sv ====
`include "gfx_consts.svh"

module gfx_raster_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LIMIT = 50000;

	logic                  clk = 1'b0;
	logic                  rst, in_valid, in_ready, out_ready;
	gfx_pkg::raster_xy     vertex_a, vertex_b, vertex_c;
	gfx_pkg::frag_xy_lanes fragments, held_frags;
	gfx_pkg::bary_lanes    barys, held_barys;
	gfx_pkg::paint_lanes   out_valid, held_valid;
	logic                  held, bp_on, ready_next;

	integer seed = 32'h6df5;
	int     value_errs = 0;
	int     other_errs = 0;
	int     checked = 0;

	// expected painted pixels, oldest first.
	gfx_pkg::frag_xy   exp_frags[$];
	gfx_pkg::fixed_tri exp_barys[$];

	gfx_raster UUT (
		.clk       (clk),
		.rst       (rst),
		.vertex_a  (vertex_a),
		.vertex_b  (vertex_b),
		.vertex_c  (vertex_c),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.fragments (fragments),
		.barys     (barys),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	always #4 clk = ~clk;

	// ####################
	// compare tasks.
	// ####################

	task automatic check_frag(input string name, input gfx_pkg::frag_xy got,
			input gfx_pkg::frag_xy want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %s: got x=%h y=%h, expected x=%h y=%h",
				name, got.x, got.y, want.x, want.y);
		end
	endtask

	task automatic check_bary(input string name, input gfx_pkg::fixed_tri got,
			input gfx_pkg::fixed_tri want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %s: got %h %h %h, expected %h %h %h",
				name, got[0], got[1], got[2], want[0], want[1], want[2]);
		end
	endtask

	task automatic check_paint(input string name, input gfx_pkg::paint_lanes got,
			input gfx_pkg::paint_lanes want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic want);
		if (got !== want) begin
			value_errs++;
			$display("FAIL %s: got %h, expected %h", name, got, want);
		end
	endtask

	// ####################
	// reference model.
	// ####################

	// all painted pixels of the aligned box, tile by tile, lane by lane.
	function automatic void expected_frags(input gfx_pkg::raster_xy a, b, c);
		int sx[3], sy[3], ex[3], ey[3], e[3];
		int lo_x, lo_y, hi_x, hi_y, px, py;
		logic hit;
		gfx_pkg::frag_xy f;
		gfx_pkg::fixed_tri t;
		sx = '{int'(a.x), int'(b.x), int'(c.x)};
		sy = '{int'(a.y), int'(b.y), int'(c.y)};
		ex = '{int'(b.x), int'(c.x), int'(a.x)};
		ey = '{int'(b.y), int'(c.y), int'(a.y)};
		lo_x = (a.x < b.x) ? a.x : b.x;
		lo_x = (c.x < lo_x) ? c.x : lo_x;
		lo_y = (a.y < b.y) ? a.y : b.y;
		lo_y = (c.y < lo_y) ? c.y : lo_y;
		hi_x = (a.x > b.x) ? a.x : b.x;
		hi_x = (c.x > hi_x) ? c.x : hi_x;
		hi_y = (a.y > b.y) ? a.y : b.y;
		hi_y = (c.y > hi_y) ? c.y : hi_y;
		lo_x = lo_x - lo_x % `GFX_RASTER_SIZE;
		lo_y = lo_y - lo_y % `GFX_RASTER_SIZE;
		for (int ty = lo_y; ty <= hi_y; ty += `GFX_RASTER_SIZE)
			for (int tx = lo_x; tx <= hi_x; tx += `GFX_RASTER_SIZE)
				for (int j = 0; j < `GFX_RASTER_SIZE; j++)
					for (int i = 0; i < `GFX_RASTER_SIZE; i++) begin
						px = tx + i;
						py = ty + j;
						hit = 1'b1;
						for (int k = 0; k < 3; k++) begin
							e[k] = (px - sx[k]) * (ey[k] - sy[k]) + (py - sy[k]) * (sx[k] - ex[k]);
							t[k] = gfx_pkg::fixed'(e[k]);
							hit = hit && e[k] >= 0;
						end
						f.x = gfx_pkg::coord'(px);
						f.y = gfx_pkg::coord'(py);
						if (hit) begin
							exp_frags.push_back(f);
							exp_barys.push_back(t);
						end
					end
	endfunction

	// ####################
	// stimulus.
	// ####################

	function automatic gfx_pkg::raster_xy random_xy(input int span);
		gfx_pkg::raster_xy r;
		r.x = gfx_pkg::coord'($unsigned($random(seed)) % span);
		r.y = gfx_pkg::coord'($unsigned($random(seed)) % span);
		return r;
	endfunction

	task automatic random_tri(output gfx_pkg::raster_xy a, b, c);
		int kind, dx, dy;
		gfx_pkg::raster_xy d, e;
		kind = int'($unsigned($random(seed)) % 4);
		a = random_xy(`GFX_SCREEN_SIZE);
		b = random_xy(`GFX_SCREEN_SIZE);
		c = random_xy(`GFX_SCREEN_SIZE);
		if (kind == 1) begin
			// touches three borders.
			a.x = 0;
			b.y = gfx_pkg::coord'(`GFX_SCREEN_SIZE - 1);
			c.x = gfx_pkg::coord'(`GFX_SCREEN_SIZE - 1);
		end else if (kind == 2) begin
			// collinear sliver.
			dx = int'($unsigned($random(seed)) % 9) - 4;
			dy = int'($unsigned($random(seed)) % 9) - 4;
			a = random_xy(44) + {8'd10, 8'd10};
			b.x = gfx_pkg::coord'(a.x + dx);
			b.y = gfx_pkg::coord'(a.y + dy);
			c.x = gfx_pkg::coord'(a.x + 2 * dx);
			c.y = gfx_pkg::coord'(a.y + 2 * dy);
		end else if (kind == 3) begin
			d = random_xy(8);
			e = random_xy(8);
			a = random_xy(`GFX_SCREEN_SIZE - 8);
			b = {a.x + d.x, a.y + d.y};
			c = {a.x + e.x, a.y + e.y};
		end
	endtask

	// leaves in_valid high, so calls back to back stream triangles.
	task automatic send_tri(input gfx_pkg::raster_xy a, b, c);
		int n;
		vertex_a = a;
		vertex_b = b;
		vertex_c = c;
		in_valid = 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!in_ready && n < LIMIT);
		if (in_ready)
			expected_frags(a, b, c);
		else begin
			other_errs++;
			$display("timeout: a triangle was never accepted");
		end
		#1;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!in_ready && n < LIMIT);
		if (!in_ready) begin
			other_errs++;
			$display("timeout: in_ready never came back");
		end
		#1;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (exp_frags.size() != 0 && n < LIMIT);
		if (exp_frags.size() != 0) begin
			other_errs++;
			$display("timeout: %0d expected fragments never came out", exp_frags.size());
			exp_frags.delete();
			exp_barys.delete();
		end
		#1;
	endtask

	// next value drawn on the edge, driven just after it.
	always @(posedge clk) begin
		ready_next = bp_on ? ($random(seed) & 3) != 0 : 1'b1;
		#1 out_ready = ready_next;
	end

	// ####################
	// collector.
	// ####################

	task automatic take_lane(input int l);
		if (exp_frags.size() == 0) begin
			other_errs++;
			$display("unexpected fragment on lane %0d at x=%h y=%h",
				l, fragments[l].x, fragments[l].y);
		end else begin
			check_frag($sformatf("fragments[%0d]", l), fragments[l], exp_frags.pop_front());
			check_bary($sformatf("barys[%0d]", l), barys[l], exp_barys.pop_front());
			checked++;
		end
	endtask

	always @(posedge clk) begin
		if (rst)
			held = 1'b0;
		else begin
			// a refused tile must come back unchanged.
			if (held) begin
				check_paint("out_valid", out_valid, held_valid);
				for (int l = 0; l < `GFX_FINE_LANES; l++) begin
					check_frag($sformatf("held fragments[%0d]", l), fragments[l], held_frags[l]);
					check_bary($sformatf("held barys[%0d]", l), barys[l], held_barys[l]);
				end
			end
			for (int l = 0; l < `GFX_FINE_LANES; l++)
				if (out_valid[l] && out_ready)
					take_lane(l);
			held = |out_valid && !out_ready;
			held_valid = out_valid;
			held_frags = fragments;
			held_barys = barys;
		end
	end

	initial begin
		gfx_pkg::raster_xy a, b, c;
		rst = 1'b1;
		in_valid = 1'b0;
		out_ready = 1'b1;
		bp_on = 1'b0;
		vertex_a = '0;
		vertex_b = '0;
		vertex_c = '0;
		@(posedge clk);
		for (int n = 0; n < 5; n++) begin
			@(posedge clk);
			check_paint("out_valid", out_valid, '0);
			check_ready("in_ready", in_ready, 1'b1);
			if (n == 2)
				#1 rst = 1'b0;
		end
		#1;

		a = {8'd3, 8'd5};
		b = {8'd6, 8'd20};
		c = {8'd17, 8'd9};
		send_tri(a, b, c);
		in_valid = 1'b0;
		wait_drain();

		// wound the other way, nothing paints.
		// setup holds two, so the fourth waits for the walker.
		for (int n = 0; n < 4; n++)
			send_tri(a, c, b);
		in_valid = 1'b0;
		wait_ready();
		wait_drain();

		for (int pass = 0; pass < 2; pass++) begin
			bp_on = pass == 1;
			for (int n = 0; n < 30; n++) begin
				random_tri(a, b, c);
				send_tri(a, b, c);
				in_valid = 1'b0;
				wait_drain();
			end
		end

		// several triangles in flight at once.
		for (int n = 0; n < 12; n++) begin
			random_tri(a, b, c);
			send_tri(a, b, c);
		end
		in_valid = 1'b0;
		wait_drain();
		wait_ready();

		$display("errors: %0d value mismatches, %0d other failures, %0d fragments checked",
			value_errs, other_errs, checked);
		if (value_errs == 0 && other_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== source/gfx_raster.sv ====
`include "gfx_consts.svh"

module gfx_raster (
	input  logic                  clk,
	input  logic                  rst,

	input  gfx_pkg::raster_xy     vertex_a,
	input  gfx_pkg::raster_xy     vertex_b,
	input  gfx_pkg::raster_xy     vertex_c,
	input  logic                  in_valid,
	output logic                  in_ready,

	output gfx_pkg::frag_xy_lanes fragments,
	output gfx_pkg::bary_lanes    barys,
	output gfx_pkg::paint_lanes   out_valid,
	input  logic                  out_ready
);

	logic                  setup_stall, setup_valid, coarse_ready;
	gfx_pkg::raster_setup  setup;

	logic                  coarse_valid, fine_ready, fine_stall, fine_valid, fine_drain;
	gfx_pkg::raster_xy     coarse_pos;
	gfx_pkg::fixed_tri     coarse_corners;
	gfx_pkg::edge_coef_tri coarse_coefs;
	gfx_pkg::paint_lanes   paint;

	// ####################
	// setup.
	// ####################

	gfx_pipeline_flow #(.STAGES(`GFX_SETUP_STAGES)) setup_flow (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_valid (setup_valid),
		.out_ready (coarse_ready),
		.stall     (setup_stall)
	);

	gfx_setup setup_stage (
		.clk      (clk),
		.stall    (setup_stall),
		.vertex_a (vertex_a),
		.vertex_b (vertex_b),
		.vertex_c (vertex_c),
		.setup    (setup)
	);

	gfx_raster_coarse coarse (
		.clk       (clk),
		.rst       (rst),
		.setup     (setup),
		.in_valid  (setup_valid),
		.in_ready  (coarse_ready),
		.pos       (coarse_pos),
		.corners   (coarse_corners),
		.coefs     (coarse_coefs),
		.out_valid (coarse_valid),
		.out_ready (fine_ready)
	);

	// ####################
	// fine lanes.
	// ####################

	// a tile with nothing painted leaves without the consumer.
	assign fine_drain = out_ready || !(|paint);
	assign out_valid  = {`GFX_FINE_LANES{fine_valid}} & paint;

	gfx_pipeline_flow #(.STAGES(`GFX_FINE_STAGES)) fine_flow (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (coarse_valid),
		.in_ready  (fine_ready),
		.out_valid (fine_valid),
		.out_ready (fine_drain),
		.stall     (fine_stall)
	);

	for (genvar j = 0; j < `GFX_RASTER_SIZE; j++) begin : fine_y
		for (genvar i = 0; i < `GFX_RASTER_SIZE; i++) begin : fine_x
			gfx_raster_fine #(.X(i), .Y(j)) fine (
				.clk      (clk),
				.stall    (fine_stall),
				.pos      (coarse_pos),
				.corners  (coarse_corners),
				.coefs    (coarse_coefs),
				.fragment (fragments[j * `GFX_RASTER_SIZE + i]),
				.barys    (barys[j * `GFX_RASTER_SIZE + i]),
				.paint    (paint[j * `GFX_RASTER_SIZE + i])
			);
		end
	end

	// held fragments don't change under the consumer.
	assert property (@(posedge clk) disable iff (rst)
		(|out_valid && !out_ready) |=> $stable(out_valid) && $stable(fragments) &&
			$stable(barys))
		else $error("fragment output changed before it was accepted");

endmodule

// ==== source/gfx_raster_fine.sv ====
module gfx_raster_fine #(
	parameter int X = 0,
	parameter int Y = 0
) (
	input  logic                  clk,
	input  logic                  stall,

	input  gfx_pkg::raster_xy     pos,
	input  gfx_pkg::fixed_tri     corners,
	input  gfx_pkg::edge_coef_tri coefs,

	output gfx_pkg::frag_xy       fragment,
	output gfx_pkg::fixed_tri     barys,
	output logic                  paint
);

	localparam gfx_pkg::fixed OFS_X = gfx_pkg::fixed'(X);
	localparam gfx_pkg::fixed OFS_Y = gfx_pkg::fixed'(Y);

	// ####################
	// compute register.
	// ####################

	gfx_pkg::frag_xy   frag_d, frag_s1;
	gfx_pkg::fixed_tri vals_d, vals_s1;

	always_comb begin
		frag_d.x = pos.x + gfx_pkg::coord'(X);
		frag_d.y = pos.y + gfx_pkg::coord'(Y);

		for (int k = 0; k < 3; k++)
			vals_d[k] = corners[k] + OFS_X * coefs[k].x + OFS_Y * coefs[k].y;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			frag_s1 <= frag_d;
			vals_s1 <= vals_d;
		end
	end

	// ####################
	// output register.
	// ####################

	logic in_tri;

	// inside when no edge value is negative.
	always_comb begin
		in_tri = 1'b1;
		for (int k = 0; k < 3; k++)
			in_tri = in_tri && $signed(vals_s1[k]) >= 0;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fragment <= frag_s1;
			barys    <= vals_s1;
			paint    <= in_tri;
		end
	end

endmodule

// ==== source/gfx_raster_coarse.sv ====
`include "gfx_consts.svh"

module gfx_raster_coarse (
	input  logic                  clk,
	input  logic                  rst,

	input  gfx_pkg::raster_setup  setup,
	input  logic                  in_valid,
	output logic                  in_ready,

	output gfx_pkg::raster_xy     pos,
	output gfx_pkg::fixed_tri     corners,
	output gfx_pkg::edge_coef_tri coefs,
	output logic                  out_valid,
	input  logic                  out_ready
);

	localparam gfx_pkg::fixed STEP = gfx_pkg::fixed'(`GFX_RASTER_SIZE);

	typedef enum logic {
		state_idle,
		state_walk
	} walk_state;

	walk_state            state;
	gfx_pkg::raster_setup setup_q;

	// edge values at the start of the current tile row.
	gfx_pkg::fixed_tri row;

	gfx_pkg::fixed_tri next_col, next_row;
	logic              reject, advance, last_x, last_y;

	// true when all four pixels of the tile fail this edge.
	function automatic logic outside(input gfx_pkg::fixed c, input gfx_pkg::edge_coef k);
		gfx_pkg::fixed c_x, c_y, c_xy;
		c_x  = c + k.x;
		c_y  = c + k.y;
		c_xy = c_x + k.y;
		return (c < 0) && (c_x < 0) && (c_y < 0) && (c_xy < 0);
	endfunction

	always_comb begin
		reject = 1'b0;
		for (int k = 0; k < 3; k++) begin
			reject   = reject || outside(corners[k], setup_q.coefs[k]);
			next_col[k] = corners[k] + STEP * setup_q.coefs[k].x;
			next_row[k] = row[k] + STEP * setup_q.coefs[k].y;
		end
	end

	assign last_x = pos.x + `GFX_RASTER_SIZE > setup_q.box.max.x;
	assign last_y = pos.y + `GFX_RASTER_SIZE > setup_q.box.max.y;

	// one candidate per cycle, rejected ones go by unseen.
	assign in_ready  = state == state_idle;
	assign out_valid = state == state_walk && !reject;
	assign advance   = state == state_walk && (reject || out_ready);

	assign coefs = setup_q.coefs;

	always_ff @(posedge clk) begin
		if (rst)
			state <= state_idle;
		else if (in_valid && in_ready)
			state <= state_walk;
		else if (advance && last_x && last_y)
			state <= state_idle;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			setup_q <= setup;
			pos     <= setup.box.min;
			corners <= setup.edge_refs;
			row     <= setup.edge_refs;
		end else if (advance) begin
			if (!last_x) begin
				pos.x   <= pos.x + `GFX_RASTER_SIZE;
				corners <= next_col;
			end else begin
				// wrap to the next row.
				pos.x   <= setup_q.box.min.x;
				pos.y   <= pos.y + `GFX_RASTER_SIZE;
				row     <= next_row;
				corners <= next_row;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		out_valid |-> pos.x >= setup_q.box.min.x && pos.x <= setup_q.box.max.x &&
			pos.y >= setup_q.box.min.y && pos.y <= setup_q.box.max.y &&
			pos.x < `GFX_SCREEN_SIZE && pos.y < `GFX_SCREEN_SIZE)
		else $error("coarse walker left the bounding box");

endmodule

// ==== source/gfx_setup.sv ====
`include "gfx_consts.svh"

module gfx_setup (
	input  logic                 clk,
	input  logic                 stall,

	input  gfx_pkg::raster_xy    vertex_a,
	input  gfx_pkg::raster_xy    vertex_b,
	input  gfx_pkg::raster_xy    vertex_c,

	output gfx_pkg::raster_setup setup
);

	function automatic gfx_pkg::coord min3(
		input gfx_pkg::coord p,
		input gfx_pkg::coord q,
		input gfx_pkg::coord r
	);
		gfx_pkg::coord m;
		m = (p < q) ? p : q;
		return (m < r) ? m : r;
	endfunction

	function automatic gfx_pkg::coord max3(
		input gfx_pkg::coord p,
		input gfx_pkg::coord q,
		input gfx_pkg::coord r
	);
		gfx_pkg::coord m;
		m = (p > q) ? p : q;
		return (m > r) ? m : r;
	endfunction

	// edge k runs from starts[k] to ends[k].
	gfx_pkg::raster_xy [2:0] starts, ends;

	assign starts = {vertex_c, vertex_b, vertex_a};
	assign ends   = {vertex_a, vertex_c, vertex_b};

	// ####################
	// stage one.
	// ####################

	gfx_pkg::edge_coef_tri   coefs_d, coefs_s1;
	gfx_pkg::raster_box      box_d, box_s1;
	gfx_pkg::raster_xy [2:0] starts_s1;
	gfx_pkg::raster_xy       lo;

	always_comb begin
		for (int k = 0; k < 3; k++) begin
			coefs_d[k].x = gfx_pkg::fixed'(ends[k].y) - gfx_pkg::fixed'(starts[k].y);
			coefs_d[k].y = gfx_pkg::fixed'(starts[k].x) - gfx_pkg::fixed'(ends[k].x);
		end

		lo.x = min3(vertex_a.x, vertex_b.x, vertex_c.x);
		lo.y = min3(vertex_a.y, vertex_b.y, vertex_c.y);

		// align to the tile grid.
		box_d.min.x = lo.x - (lo.x % `GFX_RASTER_SIZE);
		box_d.min.y = lo.y - (lo.y % `GFX_RASTER_SIZE);
		box_d.max.x = max3(vertex_a.x, vertex_b.x, vertex_c.x);
		box_d.max.y = max3(vertex_a.y, vertex_b.y, vertex_c.y);
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			coefs_s1  <= coefs_d;
			box_s1    <= box_d;
			starts_s1 <= starts;
		end
	end

	// ####################
	// stage two.
	// ####################

	gfx_pkg::fixed_tri refs_d;

	// edge values at the aligned box corner.
	always_comb begin
		for (int k = 0; k < 3; k++)
			refs_d[k] =
				(gfx_pkg::fixed'(box_s1.min.x) - gfx_pkg::fixed'(starts_s1[k].x)) * coefs_s1[k].x +
				(gfx_pkg::fixed'(box_s1.min.y) - gfx_pkg::fixed'(starts_s1[k].y)) * coefs_s1[k].y;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			setup.coefs     <= coefs_s1;
			setup.box       <= box_s1;
			setup.edge_refs <= refs_d;
		end
	end

endmodule

// ==== source/gfx_pipeline_flow.sv ====
module gfx_pipeline_flow #(
	parameter int STAGES = 2
) (
	input  logic clk,
	input  logic rst,

	input  logic in_valid,
	output logic in_ready,

	output logic out_valid,
	input  logic out_ready,

	output logic stall
);

	// one bit per stage, bit 0 is the entry.
	logic [STAGES - 1:0] valid;

	assign out_valid = valid[STAGES - 1];

	// the whole pipe freezes when the tail can't leave.
	assign stall    = valid[STAGES - 1] && !out_ready;
	assign in_ready = !stall;

	always_ff @(posedge clk) begin
		if (rst)
			valid <= '0;
		else if (!stall)
			valid <= (valid << 1) | STAGES'(in_valid);
	end

	// upstream keeps valid up until it is taken.
	assert property (@(posedge clk) disable iff (rst) in_valid && !in_ready |=> in_valid)
		else $error("pipeline flow input dropped before it was accepted");

endmodule

// ==== source/gfx_pkg.sv ====
`include "gfx_consts.svh"

package gfx_pkg;

	// ####################
	// scalars.
	// ####################

	// pixel coordinate, always positive.
	typedef logic [`GFX_COORD_BITS - 1:0] coord;

	// edge function value, signed.
	typedef logic signed [`GFX_FIXED_BITS - 1:0] fixed;

	// ####################
	// positions.
	// ####################

	// vertex or tile origin.
	typedef struct packed {
		coord x;
		coord y;
	} raster_xy;

	typedef raster_xy frag_xy;

	// min is aligned down to the tile grid.
	typedef struct packed {
		raster_xy min;
		raster_xy max;
	} raster_box;

	// ####################
	// edge functions.
	// ####################

	// one value per edge, index is the edge number.
	typedef fixed [2:0] fixed_tri;

	// x step and y step of one edge.
	typedef struct packed {
		fixed x;
		fixed y;
	} edge_coef;

	typedef edge_coef [2:0] edge_coef_tri;

	// what the walker needs for one triangle.
	typedef struct packed {
		edge_coef_tri coefs;
		raster_box    box;
		fixed_tri     edge_refs;
	} raster_setup;

	// ####################
	// fine lanes.
	// ####################

	// lane j * 2 + i holds pixel (i, j) of the tile.
	typedef frag_xy   [`GFX_FINE_LANES - 1:0] frag_xy_lanes;
	typedef fixed_tri [`GFX_FINE_LANES - 1:0] bary_lanes;
	typedef logic     [`GFX_FINE_LANES - 1:0] paint_lanes;

endpackage

// ==== include/gfx_consts.svh ====
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// ####################
// screen and tiles.
// ####################

// square screen, pixels per side.
`define GFX_SCREEN_SIZE 64

// tile side and pixels per tile.
`define GFX_RASTER_SIZE 2
`define GFX_FINE_LANES  4

// ####################
// widths and depths.
// ####################

`define GFX_COORD_BITS 8
`define GFX_FIXED_BITS 16

`define GFX_SETUP_STAGES 2
`define GFX_FINE_STAGES  2

`endif
